// ==== hw/cache_pkg.sv ====
package cache_pkg;

    localparam int ADDR_W   = 32;  // Byte address
    localparam int DATA_W   = 32;  // One word per line
    localparam int OFFSET_W = 2;   // Byte offset inside a word

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // Byte lanes touched by an access, halfwords aligned down
    function automatic logic [3:0] lane_mask(access_size_e size, logic [OFFSET_W-1:0] offset);
        case (size)
            SIZE_BYTE: return 4'b0001 << offset;
            SIZE_HALF: return 4'b0011 << {offset[1], 1'b0};
            default:   return 4'b1111;
        endcase
    endfunction

    // Write data arrives right-aligned; lowest set mask bit gives its lane position
    function automatic logic [DATA_W-1:0] lane_merge(logic [DATA_W-1:0] old_word,
                                                    logic [DATA_W-1:0] new_data,
                                                    logic [3:0]        mask);
        logic [DATA_W-1:0] result;
        logic [DATA_W-1:0] aligned;
        logic [4:0]        shift;
        result = old_word;
        shift  = '0;
        for (int b = 3; b >= 0; b--) begin
            if (mask[b]) shift = 5'(8 * b);  // Ends on the lowest lane
        end
        aligned = new_data << shift;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) result[8*b +: 8] = aligned[8*b +: 8];
        end
        return result;
    endfunction

    // Move the addressed lanes down, upper bits zero
    function automatic logic [DATA_W-1:0] lane_extract(logic [DATA_W-1:0] word,
                                                      access_size_e      size,
                                                      logic [OFFSET_W-1:0] offset);
        logic [DATA_W-1:0] shifted;
        case (size)
            SIZE_BYTE: begin
                shifted = word >> {offset, 3'b000};
                return {{(DATA_W-8){1'b0}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                shifted = word >> {offset[1], 4'b0000};
                return {{(DATA_W-16){1'b0}}, shifted[15:0]};
            end
            default: return word;
        endcase
    endfunction

endpackage

// ==== hw/mem_port_if.sv ====
`timescale 1ns/1ps

// One request in flight, req and ack are single-cycle pulses
interface mem_port_if import cache_pkg::*; ();

    logic              req;    // Request strobe
    logic              we;     // Write enable, held until ack
    logic [ADDR_W-1:0] addr;   // Byte address, held until ack
    logic [DATA_W-1:0] wdata;  // Write data, held until ack
    access_size_e      size;   // Access width, held until ack
    logic [DATA_W-1:0] rdata;  // Valid in the ack cycle of a read
    logic              ack;    // Completion strobe

    modport master (
        output req, we, addr, wdata, size,
        input  rdata, ack
    );

    modport slave (
        input  req, we, addr, wdata, size,
        output rdata, ack
    );

endinterface

// ==== hw/lru_age_tracker.sv ====
`timescale 1ns/1ps

module lru_age_tracker #(
    parameter int SETS = 64,
    parameter int WAYS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [$clog2(SETS)-1:0] set_i,
    input  logic                    touch_i,   // Make way_i the youngest
    input  logic [$clog2(WAYS)-1:0] way_i,
    output logic [$clog2(WAYS)-1:0] victim_o   // Oldest way of set_i
);

    localparam int AGE_W = $clog2(WAYS);
    localparam int WAY_W = $clog2(WAYS);

    logic [AGE_W-1:0] age_q [SETS][WAYS];
    logic [AGE_W-1:0] max_age;

    // Strict compare, so the lowest index wins a tie
    always_comb begin
        victim_o = '0;
        max_age  = age_q[set_i][0];
        for (int w = 1; w < WAYS; w++) begin
            if (age_q[set_i][w] > max_age) begin
                max_age  = age_q[set_i][w];
                victim_o = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < WAYS; w++) begin
                if (WAY_W'(w) == way_i) begin
                    age_q[set_i][w] <= '0;
                end else if (age_q[set_i][w] != AGE_W'(WAYS - 1)) begin
                    age_q[set_i][w] <= age_q[set_i][w] + 1'b1;  // Saturates at WAYS-1
                end
            end
        end
    end

endmodule

// ==== hw/l1_direct_cache.sv ====
`timescale 1ns/1ps

module l1_direct_cache import cache_pkg::*; #(
    parameter int L1_SETS = 16
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_i,     // Taken only while idle
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  access_size_e      size_i,
    input  logic              l2_hit_i,  // L2 hit level, valid with lower ack
    output logic              busy_o,
    output logic              done_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              l1_hit_o,
    output logic              l2_hit_o,
    mem_port_if.master        lower_port
);

    localparam int IDX_W = $clog2(L1_SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;

    typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_WAIT, S_RESP} state_e;

    state_e            state_q;
    logic              we_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    access_size_e      size_q;
    logic [DATA_W-1:0] resp_word_q;  // Word returned by L2
    logic              l1_hit_q;
    logic              l2_hit_q;

    logic [L1_SETS-1:0] valid_q;
    logic [TAG_W-1:0]   tag_mem  [L1_SETS];
    logic [DATA_W-1:0]  data_mem [L1_SETS];

    logic [IDX_W-1:0]    idx;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
    logic                hit;
    logic                read_hit;

    assign idx      = addr_q[OFFSET_W +: IDX_W];
    assign tag      = addr_q[ADDR_W-1 -: TAG_W];
    assign offset   = addr_q[OFFSET_W-1:0];
    assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
    assign read_hit = (state_q == S_LOOKUP) && !we_q && hit;  // Only case served locally

    // Misses and all writes go down one cycle after the request
    assign lower_port.req   = (state_q == S_LOOKUP) && !read_hit;
    assign lower_port.we    = we_q;
    assign lower_port.addr  = addr_q;
    assign lower_port.wdata = wdata_q;
    assign lower_port.size  = size_q;

    assign busy_o   = (state_q != S_IDLE);
    assign done_o   = read_hit || (state_q == S_RESP);
    assign rdata_o  = lane_extract(read_hit ? data_mem[idx] : resp_word_q, size_q, offset);
    assign l1_hit_o = (state_q == S_LOOKUP) ? hit : l1_hit_q;
    assign l2_hit_o = (state_q == S_RESP) && l2_hit_q;  // Not looked up on an L1 read hit

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= S_IDLE;
            valid_q  <= '0;
            l1_hit_q <= 1'b0;
            l2_hit_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE:   if (req_i) state_q <= S_LOOKUP;
                S_LOOKUP: begin
                    l1_hit_q <= hit;
                    state_q  <= read_hit ? S_IDLE : S_WAIT;
                end
                S_WAIT: begin
                    if (lower_port.ack) begin
                        l2_hit_q <= l2_hit_i;
                        if (!we_q) valid_q[idx] <= 1'b1;  // Read fill, writes never allocate
                        state_q <= S_RESP;
                    end
                end
                default:  state_q <= S_IDLE;  // S_RESP
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_i) begin
            we_q    <= we_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            size_q  <= size_i;
        end
        // Write hit keeps the line current, the write still goes through
        if (state_q == S_LOOKUP && we_q && hit) begin
            data_mem[idx] <= lane_merge(data_mem[idx], wdata_q, lane_mask(size_q, offset));
        end
        if (state_q == S_WAIT && lower_port.ack) begin
            resp_word_q <= lower_port.rdata;
            if (!we_q) begin
                tag_mem[idx]  <= tag;
                data_mem[idx] <= lower_port.rdata;
            end
        end
    end

    // Busy only follows an accepted request
    assert property (@(posedge clk) disable iff (!rst_n_i) $rose(busy_o) |-> $past(req_i));

endmodule

// ==== hw/l2_set_assoc_cache.sv ====
`timescale 1ns/1ps

module l2_set_assoc_cache import cache_pkg::*; #(
    parameter int L2_SETS = 64,
    parameter int L2_WAYS = 4
) (
    input  logic      clk,
    input  logic      rst_n_i,
    mem_port_if.slave  upper_port,
    mem_port_if.master lower_port,
    output logic      hit_o       // Valid in the upper ack cycle
);

    localparam int SET_W = $clog2(L2_SETS);
    localparam int WAY_W = $clog2(L2_WAYS);
    localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;

    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_RD_WAIT, S_RMW_WAIT, S_WR_WAIT} state_e;

    state_e state_q;
    state_e state_d;

    logic [L2_WAYS-1:0] valid_q  [L2_SETS];
    logic [TAG_W-1:0]   tag_mem  [L2_SETS][L2_WAYS];
    logic [DATA_W-1:0]  data_mem [L2_SETS][L2_WAYS];

    logic [SET_W-1:0]   set_idx;
    logic [TAG_W-1:0]   tag;
    logic [3:0]         mask;
    logic [L2_WAYS-1:0] match;
    logic               hit;
    logic               hit_q;
    logic [WAY_W-1:0]   hit_way;
    logic [WAY_W-1:0]   victim_way;
    logic [DATA_W-1:0]  hit_word;
    logic [DATA_W-1:0]  wr_word;     // Full word sent to L3
    logic [DATA_W-1:0]  wr_word_q;
    logic               direct_wr;   // Old word known, no read needed
    logic               fill;
    logic               touch;

    // Upper master holds its request fields until ack, so no copy is kept
    assign set_idx = upper_port.addr[OFFSET_W +: SET_W];
    assign tag     = upper_port.addr[ADDR_W-1 -: TAG_W];
    assign mask    = lane_mask(upper_port.size, upper_port.addr[OFFSET_W-1:0]);

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < L2_WAYS; w++) begin
            match[w] = valid_q[set_idx][w] && (tag_mem[set_idx][w] == tag);
            if (match[w] && !hit) begin  // First match
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit_word  = data_mem[set_idx][hit_way];
    assign direct_wr = hit || (upper_port.size == SIZE_WORD);
    // Narrow write miss merges into the word just read from L3
    assign wr_word   = lane_merge((state_q == S_RMW_WAIT) ? lower_port.rdata : hit_word,
                                  upper_port.wdata, mask);
    assign fill      = (state_q == S_RD_WAIT) && lower_port.ack;
    assign touch     = ((state_q == S_LOOKUP) && hit) || fill;

    always_comb begin
        state_d        = state_q;
        lower_port.req = 1'b0;
        lower_port.we  = (state_q == S_WR_WAIT);  // Held through the write
        case (state_q)
            S_IDLE:   if (upper_port.req) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (!upper_port.we && hit) begin
                    state_d = S_IDLE;                // Served from this level
                end else begin
                    lower_port.req = 1'b1;
                    if (upper_port.we && direct_wr) begin
                        lower_port.we = 1'b1;
                        state_d       = S_WR_WAIT;
                    end else if (upper_port.we) begin
                        state_d = S_RMW_WAIT;        // Fetch old word first
                    end else begin
                        state_d = S_RD_WAIT;
                    end
                end
            end
            S_RMW_WAIT: begin
                if (lower_port.ack) begin
                    lower_port.req = 1'b1;
                    lower_port.we  = 1'b1;
                    state_d        = S_WR_WAIT;
                end
            end
            default:  if (lower_port.ack) state_d = S_IDLE;  // S_RD_WAIT, S_WR_WAIT
        endcase
    end

    assign lower_port.addr  = {upper_port.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign lower_port.size  = SIZE_WORD;
    assign lower_port.wdata = (state_q == S_WR_WAIT) ? wr_word_q : wr_word;

    assign upper_port.ack   = ((state_q == S_LOOKUP) && !upper_port.we && hit)
                           || (((state_q == S_RD_WAIT) || (state_q == S_WR_WAIT))
                               && lower_port.ack);
    assign upper_port.rdata = (state_q == S_LOOKUP) ? hit_word : lower_port.rdata;
    assign hit_o            = (state_q == S_LOOKUP) ? hit : hit_q;

    lru_age_tracker #(
        .SETS (L2_SETS),
        .WAYS (L2_WAYS)
    ) lru_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .set_i    (set_idx),
        .touch_i  (touch),
        .way_i    ((state_q == S_LOOKUP) ? hit_way : victim_way),
        .victim_o (victim_way)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            hit_q   <= 1'b0;
            for (int s = 0; s < L2_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            state_q <= state_d;
            if (state_q == S_LOOKUP) hit_q <= hit;
            if (fill) valid_q[set_idx][victim_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_LOOKUP && hit && upper_port.we) begin
            data_mem[set_idx][hit_way] <= wr_word;
        end
        if (fill) begin
            tag_mem[set_idx][victim_way]  <= tag;
            data_mem[set_idx][victim_way] <= lower_port.rdata;
        end
        if (lower_port.req && lower_port.we) wr_word_q <= wr_word;
    end

    // Fills only replace missing tags, so a set never holds one tag twice
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (state_q == S_LOOKUP) |-> $onehot0(match));

endmodule

// ==== hw/l3_backing_mem.sv ====
`timescale 1ns/1ps

module l3_backing_mem import cache_pkg::*; #(
    parameter int L3_WORDS   = 1024,
    parameter int L3_LATENCY = 4
) (
    input  logic     clk,
    input  logic     rst_n_i,
    mem_port_if.slave port
);

    localparam int IDX_W = $clog2(L3_WORDS);
    localparam int CNT_W = $clog2(L3_LATENCY + 1);

    logic [DATA_W-1:0] mem [L3_WORDS];
    logic [CNT_W-1:0]  cnt_q;     // Read countdown, zero when idle
    logic              wr_ack_q;  // Write acknowledged one cycle later
    logic [IDX_W-1:0]  idx;

    initial begin
        for (int i = 0; i < L3_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign idx        = port.addr[OFFSET_W +: IDX_W];  // Address is held until ack
    assign port.rdata = mem[idx];
    assign port.ack   = wr_ack_q || (cnt_q == CNT_W'(1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q    <= '0;
            wr_ack_q <= 1'b0;
        end else begin
            wr_ack_q <= port.req && port.we;
            if (port.req && !port.we) begin
                cnt_q <= CNT_W'(L3_LATENCY);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port.req && port.we) mem[idx] <= port.wdata;  // Always a full merged word
    end

    // Next request may come at the earliest in the read ack cycle
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (cnt_q > CNT_W'(1)) |-> !port.req);

endmodule

// ==== hw/mem_hier_top.sv ====
`timescale 1ns/1ps

module mem_hier_top import cache_pkg::*; #(
    parameter int L1_SETS    = 16,
    parameter int L2_SETS    = 64,
    parameter int L2_WAYS    = 4,
    parameter int L3_WORDS   = 1024,
    parameter int L3_LATENCY = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  access_size_e      size_i,
    output logic              busy_o,
    output logic              done_o,    // One pulse per accepted request
    output logic [DATA_W-1:0] rdata_o,
    output logic              l1_hit_o,
    output logic              l2_hit_o
);

    logic l2_hit;  // L2 hit level beside the L1-L2 port

    mem_port_if l1_l2_port ();
    mem_port_if l2_l3_port ();

    l1_direct_cache #(
        .L1_SETS (L1_SETS)
    ) l1_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .size_i     (size_i),
        .l2_hit_i   (l2_hit),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .rdata_o    (rdata_o),
        .l1_hit_o   (l1_hit_o),
        .l2_hit_o   (l2_hit_o),
        .lower_port (l1_l2_port.master)
    );

    l2_set_assoc_cache #(
        .L2_SETS (L2_SETS),
        .L2_WAYS (L2_WAYS)
    ) l2_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .upper_port (l1_l2_port.slave),
        .lower_port (l2_l3_port.master),
        .hit_o      (l2_hit)
    );

    l3_backing_mem #(
        .L3_WORDS   (L3_WORDS),
        .L3_LATENCY (L3_LATENCY)
    ) l3_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .port    (l2_l3_port.slave)
    );

endmodule

// ==== test/tb_mem_hier.sv ====
`timescale 1ns/1ps

module tb_mem_hier import cache_pkg::*; ();

    localparam int L3_WORDS   = 1024;
    localparam int L3_LATENCY = 4;
    localparam int REF_BYTES  = 4 * L3_WORDS;      // Flat byte image of L3
    localparam int MA_W       = $clog2(REF_BYTES);
    localparam int MAX_TESTS  = 40;
    localparam int SLOT       = 3 + L3_LATENCY + 4;  // Cycle budget per entry

    logic              clk;
    logic              rst_n_i;
    logic              req_i;
    logic              we_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    access_size_e      size_i;
    logic              busy_o;
    logic              done_o;
    logic [DATA_W-1:0] rdata_o;
    logic              l1_hit_o;
    logic              l2_hit_o;

    // Stimulus table with one slot per entry
    string             tc_name      [MAX_TESTS];
    logic              tc_we        [MAX_TESTS];
    logic [ADDR_W-1:0] tc_addr      [MAX_TESTS];
    logic [DATA_W-1:0] tc_wdata     [MAX_TESTS];
    access_size_e      tc_size      [MAX_TESTS];
    logic [DATA_W-1:0] tc_exp_rdata [MAX_TESTS];
    logic              tc_exp_l1    [MAX_TESTS];
    logic              tc_exp_l2    [MAX_TESTS];
    int                n_tests = 0;

    logic [7:0]        ref_mem [REF_BYTES];  // Always the current L3 contents
    integer            seed;
    int                pass_count = 0;
    int                fail_count = 0;
    int                done_count = 0;
    logic [DATA_W-1:0] done_rdata;  // Outputs captured in the done_o cycle
    logic              done_l1;
    logic              done_l2;

    mem_hier_top #(
        .L3_WORDS   (L3_WORDS),
        .L3_LATENCY (L3_LATENCY)
    ) dut_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .size_i   (size_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .rdata_o  (rdata_o),
        .l1_hit_o (l1_hit_o),
        .l2_hit_o (l2_hit_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Halfwords and words align down and narrow reads are zero-extended
    function automatic logic [DATA_W-1:0] read_model(input logic [MA_W-1:0] a,
                                                     input access_size_e    size);
        logic [MA_W-1:0] h;
        logic [MA_W-1:0] w;
        h = {a[MA_W-1:1], 1'b0};
        w = {a[MA_W-1:2], 2'b00};
        case (size)
            SIZE_BYTE: return {24'h0, ref_mem[a]};
            SIZE_HALF: return {16'h0, ref_mem[h + 1'b1], ref_mem[h]};
            default:   return {ref_mem[w + 2'd3], ref_mem[w + 2'd2],
                               ref_mem[w + 1'b1], ref_mem[w]};
        endcase
    endfunction

    // Right-aligned write data lands on the addressed lanes
    task automatic write_model(input logic [MA_W-1:0] a, input access_size_e size,
                               input logic [DATA_W-1:0] d);
        logic [MA_W-1:0] h;
        logic [MA_W-1:0] w;
        h = {a[MA_W-1:1], 1'b0};
        w = {a[MA_W-1:2], 2'b00};
        case (size)
            SIZE_BYTE: ref_mem[a] = d[7:0];
            SIZE_HALF: begin
                ref_mem[h]        = d[7:0];
                ref_mem[h + 1'b1] = d[15:8];
            end
            default: begin
                ref_mem[w]        = d[7:0];
                ref_mem[w + 1'b1] = d[15:8];
                ref_mem[w + 2'd2] = d[23:16];
                ref_mem[w + 2'd3] = d[31:24];
            end
        endcase
    endtask

    // Expected read data comes from the model at table build time
    task automatic add_test(input string name, input logic we, input logic [ADDR_W-1:0] addr,
                            input access_size_e size, input logic l1, input logic l2);
        logic [DATA_W-1:0] data;
        data = '0;
        if (we) begin
            data = $random(seed);
            write_model(addr[MA_W-1:0], size, data);
        end
        tc_name[n_tests]      = name;
        tc_we[n_tests]        = we;
        tc_addr[n_tests]      = addr;
        tc_wdata[n_tests]     = data;
        tc_size[n_tests]      = size;
        tc_exp_rdata[n_tests] = we ? '0 : read_model(addr[MA_W-1:0], size);
        tc_exp_l1[n_tests]    = l1;
        tc_exp_l2[n_tests]    = l2;
        n_tests++;
    endtask

    task automatic build_table();
        add_test("rd_cold",          1'b0, 32'h100, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_repeat",        1'b0, 32'h100, SIZE_WORD, 1'b1, 1'b0);
        add_test("wr_byte_1",        1'b1, 32'h101, SIZE_BYTE, 1'b1, 1'b1);
        add_test("rd_word_b",        1'b0, 32'h100, SIZE_WORD, 1'b1, 1'b0);
        add_test("rd_byte_1",        1'b0, 32'h101, SIZE_BYTE, 1'b1, 1'b0);
        add_test("wr_half_2",        1'b1, 32'h102, SIZE_HALF, 1'b1, 1'b1);
        add_test("rd_word_h",        1'b0, 32'h100, SIZE_WORD, 1'b1, 1'b0);
        add_test("rd_half_2",        1'b0, 32'h102, SIZE_HALF, 1'b1, 1'b0);
        add_test("wr_word_0",        1'b1, 32'h100, SIZE_WORD, 1'b1, 1'b1);
        add_test("rd_word_w",        1'b0, 32'h100, SIZE_WORD, 1'b1, 1'b0);
        add_test("rd_byte_3",        1'b0, 32'h103, SIZE_BYTE, 1'b1, 1'b0);
        add_test("rd_half_0",        1'b0, 32'h100, SIZE_HALF, 1'b1, 1'b0);
        // Same L1 index but different tags
        add_test("wr_alias_a",       1'b1, 32'h204, SIZE_WORD, 1'b0, 1'b0);
        add_test("wr_alias_b",       1'b1, 32'h244, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_alias_a1",      1'b0, 32'h204, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_alias_b1",      1'b0, 32'h244, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_alias_a2",      1'b0, 32'h204, SIZE_WORD, 1'b0, 1'b1);
        add_test("rd_alias_b2",      1'b0, 32'h244, SIZE_WORD, 1'b0, 1'b1);
        // Five tags in L2 set 2 where the first one ages out
        add_test("wr_set_e",         1'b1, 32'h408, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_set_a",         1'b0, 32'h008, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_set_b",         1'b0, 32'h108, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_set_c",         1'b0, 32'h208, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_set_d",         1'b0, 32'h308, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_set_e",         1'b0, 32'h408, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_set_a_evicted", 1'b0, 32'h008, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_set_e_kept",    1'b0, 32'h408, SIZE_WORD, 1'b0, 1'b1);
        // Narrow writes to lines held nowhere
        add_test("wr_unc_byte",      1'b1, 32'h7a3, SIZE_BYTE, 1'b0, 1'b0);
        add_test("rd_unc_word",      1'b0, 32'h7a0, SIZE_WORD, 1'b0, 1'b0);
        add_test("rd_unc_byte",      1'b0, 32'h7a3, SIZE_BYTE, 1'b1, 1'b0);
        add_test("wr_unc_half",      1'b1, 32'h7c6, SIZE_HALF, 1'b0, 1'b0);
        add_test("rd_unc_half",      1'b0, 32'h7c6, SIZE_HALF, 1'b0, 1'b0);
    endtask

    // Capture outputs mid-cycle away from the clock edge
    always @(negedge clk) begin
        if (rst_n_i && done_o) begin
            done_rdata = rdata_o;
            done_l1    = l1_hit_o;
            done_l2    = l2_hit_o;
            done_count = done_count + 1;
        end
    end

    task automatic apply_test(input int i);
        int start;
        int errs;
        start = done_count;
        errs  = 0;
        @(posedge clk);
        req_i   <= 1'b1;
        we_i    <= tc_we[i];
        addr_i  <= tc_addr[i];
        wdata_i <= tc_wdata[i];
        size_i  <= tc_size[i];
        @(posedge clk);
        req_i <= i[0];  // Odd entries keep req_i high while busy_o is up
        @(negedge clk);
        if (busy_o !== 1'b1) begin
            $display("[FAIL] %s busy_o expected 1 actual %0b", tc_name[i], busy_o);
            errs++;
        end
        @(posedge clk);
        req_i <= 1'b0;
        while (done_count == start) @(posedge clk);
        if (!tc_we[i] && done_rdata !== tc_exp_rdata[i]) begin
            $display("[FAIL] %s rdata expected %08h actual %08h",
                     tc_name[i], tc_exp_rdata[i], done_rdata);
            errs++;
        end
        if (done_l1 !== tc_exp_l1[i]) begin
            $display("[FAIL] %s l1_hit expected %0b actual %0b",
                     tc_name[i], tc_exp_l1[i], done_l1);
            errs++;
        end
        if (done_l2 !== tc_exp_l2[i]) begin
            $display("[FAIL] %s l2_hit expected %0b actual %0b",
                     tc_name[i], tc_exp_l2[i], done_l2);
            errs++;
        end
        if (errs == 0) begin
            $display("[PASS] %s", tc_name[i]);
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        size_i  = SIZE_WORD;
        seed    = 32'h536f2696;
        for (int i = 0; i < REF_BYTES; i++) begin
            ref_mem[i] = 8'h00;  // L3 starts cleared
        end
        build_table();
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            apply_test(i);
        end
        repeat (SLOT) @(posedge clk);  // Room for a wrongly accepted request to finish
        if (done_count != n_tests) begin
            $display("done_o pulsed %0d times for %0d requests", done_count, n_tests);
            fail_count++;
        end
        $display("Summary %0d passed, %0d failed, %0d entries", pass_count, fail_count, n_tests);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog allows one slot per entry plus the final drain
    initial begin
        @(posedge rst_n_i);
        repeat ((n_tests + 1) * SLOT) @(posedge clk);
        $display("Timeout after %0d cycles, a request never completed", (n_tests + 1) * SLOT);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== mem_hier_top.f ====
hw/cache_pkg.sv
hw/mem_port_if.sv
hw/lru_age_tracker.sv
hw/l1_direct_cache.sv
hw/l2_set_assoc_cache.sv
hw/l3_backing_mem.sv
hw/mem_hier_top.sv
test/tb_mem_hier.sv

// ==== Makefile ====
TOP  := tb_mem_hier
SRCS := $(shell cat mem_hier_top.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): $(SRCS) mem_hier_top.f
	verilator --binary --assert -sv --top-module $(TOP) -f mem_hier_top.f -Mdir obj_dir -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
